// ==== files.f ====
rtl/rd_pkg.sv
rtl/rd_cfg_regs.sv
rtl/rd_req_split.sv
rtl/rd_alloc.sv
rtl/rd_cpl_retire.sv
rtl/rd_outbound_top.sv
verification/rd_tb_clk.sv
verification/rd_tb.sv

// ==== rtl/rd_alloc.sv ====
`timescale 1ns/10ps

module rd_alloc (
    input  logic             clk,
    input  logic             rst,
    input  rd_pkg::rd_cfg_t  cfg,
    input  logic             hdr_valid,
    output logic             hdr_ready,
    input  rd_pkg::tlp_hdr_t hdr,
    output logic             tlp_valid,
    input  logic             tlp_ready,
    output rd_pkg::rd_tlp_t  tlp,
    output logic             alloc_valid,
    output rd_pkg::alloc_t   alloc,
    input  rd_pkg::dealloc_t dealloc,
    output logic             pending
);

    // compute stage
    logic                      h_valid;
    logic                      h_ready;
    logic                      h_xfer;
    logic [rd_pkg::addr_w-1:0] h_addr;
    logic [10:0]               h_len;
    logic [rd_pkg::fch_w-1:0]  h_cplh;
    logic [rd_pkg::fcd_w-1:0]  h_cpld;

    logic [10:0]               len_full;
    logic [11:0]               cplh_pre;
    logic [11:0]               cpld_pre;
    logic [rd_pkg::fch_w-1:0]  cplh_need;
    logic [rd_pkg::fcd_w-1:0]  cpld_need;

    // resource tracking
    logic [rd_pkg::fch_w-1:0]  cplh_avail;
    logic [rd_pkg::fcd_w-1:0]  cpld_avail;
    logic [rd_pkg::fch_w:0]    cplh_sub;
    logic [rd_pkg::fcd_w:0]    cpld_sub;
    logic [rd_pkg::tag_w:0]    tag;
    logic [rd_pkg::tag_w:0]    tag_cnt;
    logic                      tag_init;
    logic [rd_pkg::bufa_w:0]   buf_avail;
    logic [11:0]               buf_sub;
    logic [rd_pkg::bufa_w-1:0] buf_addr;

    assign len_full = (hdr.len == 10'd0) ? 11'd1024 : {1'b0, hdr.len};

    // completion headers per rcb, completion data per 16 bytes
    assign cplh_pre = cfg.rcb ? ({7'b0, hdr.addr[4:0]} + {1'b0, len_full} + 12'd31)
                              : ({8'b0, hdr.addr[3:0]} + {1'b0, len_full} + 12'd15);
    assign cpld_pre = {10'b0, hdr.addr[1:0]} + {1'b0, len_full} + 12'd3;

    assign cplh_need = cfg.rcb ? {1'b0, cplh_pre[11:5]} : cplh_pre[11:4];
    assign cpld_need = {2'b0, cpld_pre[11:2]};

    assign hdr_ready = !h_valid && cfg.dma_en;
    assign h_xfer    = h_valid && h_ready;

    always_ff @(posedge clk) begin
        if (hdr_valid && hdr_ready) begin
            h_addr <= hdr.addr;
            h_len  <= len_full;
            h_cplh <= cplh_need;
            h_cpld <= cpld_need;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            h_valid <= 1'b0;
        end else if (hdr_valid && hdr_ready) begin
            h_valid <= 1'b1;
        end else if (h_xfer) begin
            h_valid <= 1'b0;
        end
    end

    // negative result means not enough credit
    assign cplh_sub = {1'b0, cplh_avail} - {1'b0, h_cplh};
    assign cpld_sub = {1'b0, cpld_avail} - {1'b0, h_cpld};
    assign buf_sub  = {2'b0, buf_avail} - {1'b0, h_len};

    always_ff @(posedge clk) begin
        if (rst) begin
            cplh_avail <= rd_pkg::fch_w'(rd_pkg::cplh_credits);
            cpld_avail <= rd_pkg::fcd_w'(rd_pkg::cpld_credits);
            buf_avail  <= {1'b1, {rd_pkg::bufa_w{1'b0}}};
            buf_addr   <= '0;
        end else begin
            cplh_avail <= (h_xfer ? cplh_sub[rd_pkg::fch_w-1:0] : cplh_avail)
                        + {{(rd_pkg::fch_w-1){1'b0}}, dealloc.cplh};
            cpld_avail <= (h_xfer ? cpld_sub[rd_pkg::fcd_w-1:0] : cpld_avail)
                        + {{(rd_pkg::fcd_w-1){1'b0}}, dealloc.cpld};
            buf_avail  <= (h_xfer ? buf_sub[rd_pkg::bufa_w:0] : buf_avail)
                        + {{rd_pkg::bufa_w{1'b0}}, dealloc.data};
            if (h_xfer) begin
                buf_addr <= buf_addr + h_len[rd_pkg::bufa_w-1:0];
            end
        end
    end

    // tag counter runs through 32 values once to clear the tag table
    always_ff @(posedge clk) begin
        if (rst) begin
            tag      <= '0;
            tag_cnt  <= '0;
            tag_init <= 1'b1;
        end else begin
            if (tag_init && (&tag)) begin
                tag_init <= 1'b0;
            end
            if (tag_init || h_xfer) begin
                tag <= tag + 1'b1;
            end
            tag_cnt <= tag_cnt + {{rd_pkg::tag_w{1'b0}}, h_xfer}
                     - {{rd_pkg::tag_w{1'b0}}, dealloc.tag};
        end
    end

    assign pending = (tag_cnt != '0);

    assign h_ready = !tag_init && !tag_cnt[rd_pkg::tag_w] && !tlp_valid &&
                     !cplh_sub[rd_pkg::fch_w] && !cpld_sub[rd_pkg::fcd_w] &&
                     !buf_sub[11];

    always_ff @(posedge clk) begin
        if (rst) begin
            alloc_valid <= 1'b0;
            tlp_valid   <= 1'b0;
        end else begin
            alloc_valid <= tag_init || h_xfer;
            if (h_xfer) begin
                tlp_valid <= 1'b1;
            end else if (tlp_ready) begin
                tlp_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        alloc.init    <= tag_init;
        alloc.tag     <= tag[rd_pkg::tag_w-1:0];
        alloc.len     <= h_len[9:0];
        alloc.addr_lo <= h_addr[4:0];
        alloc.bufa    <= buf_addr;
        if (h_xfer) begin
            tlp.addr     <= h_addr;
            tlp.len      <= h_len[9:0];
            tlp.tag      <= tag[rd_pkg::tag_w-1:0];
            tlp.be_first <= 4'hf;
            tlp.be_last  <= (h_len == 11'd1) ? 4'h0 : 4'hf;
        end
    end

endmodule

// ==== rtl/rd_cfg_regs.sv ====
`timescale 1ns/10ps

module rd_cfg_regs (
    input  logic            clk,
    input  logic            rst,
    input  rd_pkg::reg_op_e reg_op,
    input  logic [7:0]      reg_wdata,
    output logic [7:0]      reg_rdata,
    input  logic            pending,
    output rd_pkg::rd_cfg_t cfg
);

    logic [7:0] status_word;

    // status layout: pending above the control fields
    assign status_word = {3'b000, pending, cfg.mrrs, cfg.rcb, cfg.dma_en};

    // control register
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg.dma_en <= 1'b0;
            cfg.rcb    <= 1'b0;
            cfg.mrrs   <= rd_pkg::mrrs_128;
        end else if (reg_op == rd_pkg::op_wr_ctrl) begin
            cfg.dma_en <= reg_wdata[0];
            // rcb set selects 128 byte boundary
            cfg.rcb    <= reg_wdata[1];
            cfg.mrrs   <= rd_pkg::mrrs_e'(reg_wdata[3:2]);
        end
    end

    // read data returns one cycle after the op
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_rdata <= 8'h00;
        end else begin
            case (reg_op)
                rd_pkg::op_rd_status: begin
                    reg_rdata <= status_word;
                end
                default: begin
                    reg_rdata <= reg_rdata;
                end
            endcase
        end
    end

endmodule

// ==== rtl/rd_cpl_retire.sv ====
`timescale 1ns/10ps

module rd_cpl_retire (
    input  logic              clk,
    input  logic              rst,
    input  logic              alloc_valid,
    input  rd_pkg::alloc_t    alloc,
    input  logic              cpl_valid,
    input  rd_pkg::cpl_beat_t cpl,
    output logic              rsp_valid,
    output rd_pkg::rsp_beat_t rsp,
    output rd_pkg::dealloc_t  dealloc
);

    localparam int n_tags = 2 ** rd_pkg::tag_w;

    // one entry per outstanding tag
    typedef struct packed {
        logic [10:0]               rem;
        logic [4:0]                addr_lo;
        logic [rd_pkg::bufa_w-1:0] bufa;
    } tag_entry_t;

    tag_entry_t tag_tbl [n_tags];
    tag_entry_t cur;
    tag_entry_t nxt;
    tag_entry_t fresh;
    logic       last_dw;
    logic       blk_end;

    assign cur = tag_tbl[cpl.tag];

    // entry after consuming one dword
    assign nxt.rem     = cur.rem - 11'd1;
    assign nxt.addr_lo = cur.addr_lo + 5'd1;
    assign nxt.bufa    = cur.bufa + 1'b1;

    assign last_dw = (cur.rem == 11'd1);
    // dword in the last slot of a 16 byte block
    assign blk_end = (cur.addr_lo[1:0] == 2'b11);

    // init clears the entry, otherwise load the new header
    always_comb begin
        if (alloc.init) begin
            fresh = '0;
        end else begin
            fresh.rem     = (alloc.len == 10'd0) ? 11'd1024 : {1'b0, alloc.len};
            fresh.addr_lo = alloc.addr_lo;
            fresh.bufa    = alloc.bufa;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            tag_tbl[alloc.tag] <= fresh;
        end
        if (cpl_valid) begin
            tag_tbl[cpl.tag] <= nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid    <= 1'b0;
            dealloc.cplh <= 1'b0;
            dealloc.cpld <= 1'b0;
            dealloc.tag  <= 1'b0;
            dealloc.data <= 1'b0;
        end else begin
            rsp_valid    <= cpl_valid;
            dealloc.data <= cpl_valid;
            dealloc.cpld <= cpl_valid && (blk_end || cpl.eop);
            dealloc.cplh <= cpl_valid && cpl.eop;
            dealloc.tag  <= cpl_valid && last_dw;
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (cpl_valid) begin
            rsp.tag  <= cpl.tag;
            rsp.bufa <= cur.bufa;
            rsp.data <= cpl.data;
            rsp.last <= last_dw;
        end
    end

endmodule

// ==== rtl/rd_outbound_top.sv ====
`timescale 1ns/10ps

module rd_outbound_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              req_valid,
    output logic              req_ready,
    input  rd_pkg::rd_req_t   req,
    output logic              tlp_valid,
    input  logic              tlp_ready,
    output rd_pkg::rd_tlp_t   tlp,
    input  logic              cpl_valid,
    input  rd_pkg::cpl_beat_t cpl,
    output logic              rsp_valid,
    output rd_pkg::rsp_beat_t rsp,
    input  rd_pkg::reg_op_e   reg_op,
    input  logic [7:0]        reg_wdata,
    output logic [7:0]        reg_rdata,
    output logic              pending
);

    rd_pkg::rd_cfg_t  cfg;
    logic             hdr_valid;
    logic             hdr_ready;
    rd_pkg::tlp_hdr_t hdr;
    logic             alloc_valid;
    rd_pkg::alloc_t   alloc;
    rd_pkg::dealloc_t dealloc;

    rd_cfg_regs i_cfg (
        .clk(clk), .rst(rst), .reg_op(reg_op), .reg_wdata(reg_wdata),
        .reg_rdata(reg_rdata), .pending(pending), .cfg(cfg)
    );

    rd_req_split i_split (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .cfg(cfg), .hdr_valid(hdr_valid), .hdr_ready(hdr_ready), .hdr(hdr)
    );

    rd_alloc i_alloc (
        .clk(clk), .rst(rst), .cfg(cfg), .hdr_valid(hdr_valid), .hdr_ready(hdr_ready),
        .hdr(hdr), .tlp_valid(tlp_valid), .tlp_ready(tlp_ready), .tlp(tlp),
        .alloc_valid(alloc_valid), .alloc(alloc), .dealloc(dealloc), .pending(pending)
    );

    rd_cpl_retire i_retire (
        .clk(clk), .rst(rst), .alloc_valid(alloc_valid), .alloc(alloc),
        .cpl_valid(cpl_valid), .cpl(cpl), .rsp_valid(rsp_valid), .rsp(rsp),
        .dealloc(dealloc)
    );

endmodule

// ==== rtl/rd_pkg.sv ====
package rd_pkg;

    // sizes of the read path
    localparam int addr_w       = 30;
    localparam int tag_w        = 4;
    localparam int bufa_w       = 9;
    localparam int cplh_credits = 8;
    localparam int cpld_credits = 64;
    localparam int fch_w        = 8;
    localparam int fcd_w        = 12;

    typedef enum logic [1:0] {
        op_nop       = 2'd0,
        op_wr_ctrl   = 2'd1,
        op_rd_status = 2'd2
    } reg_op_e;

    typedef enum logic [1:0] {
        mrrs_128 = 2'd0,
        mrrs_256 = 2'd1,
        mrrs_512 = 2'd2
    } mrrs_e;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [10:0]       len;
    } rd_req_t;

    // len of 0 stands for 1024 dwords
    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [9:0]        len;
    } tlp_hdr_t;

    typedef struct packed {
        logic [addr_w-1:0] addr;
        logic [9:0]        len;
        logic [tag_w-1:0]  tag;
        logic [3:0]        be_first;
        logic [3:0]        be_last;
    } rd_tlp_t;

    typedef struct packed {
        logic              init;
        logic [tag_w-1:0]  tag;
        logic [9:0]        len;
        logic [4:0]        addr_lo;
        logic [bufa_w-1:0] bufa;
    } alloc_t;

    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic [31:0]       data;
        logic              eop;
    } cpl_beat_t;

    typedef struct packed {
        logic [tag_w-1:0]  tag;
        logic [bufa_w-1:0] bufa;
        logic [31:0]       data;
        logic              last;
    } rsp_beat_t;

    typedef struct packed {
        logic cplh;
        logic cpld;
        logic tag;
        logic data;
    } dealloc_t;

    typedef struct packed {
        logic  dma_en;
        logic  rcb;
        mrrs_e mrrs;
    } rd_cfg_t;

endpackage

// ==== rtl/rd_req_split.sv ====
`timescale 1ns/10ps

module rd_req_split (
    input  logic             clk,
    input  logic             rst,
    input  logic             req_valid,
    output logic             req_ready,
    input  rd_pkg::rd_req_t  req,
    input  rd_pkg::rd_cfg_t  cfg,
    output logic             hdr_valid,
    input  logic             hdr_ready,
    output rd_pkg::tlp_hdr_t hdr
);

    typedef enum logic {
        st_idle,
        st_busy
    } state_e;

    state_e                    state;
    logic [rd_pkg::addr_w-1:0] cur_addr;
    logic [10:0]               cur_len;
    logic [10:0]               mrrs_dist;
    logic [10:0]               page_dist;
    logic [10:0]               step;
    logic                      req_xfer;
    logic                      hdr_xfer;

    assign req_xfer = req_valid && req_ready;
    assign hdr_xfer = hdr_valid && hdr_ready;

    // dwords up to the next mrrs and 4 KB boundaries
    always_comb begin
        case (cfg.mrrs)
            rd_pkg::mrrs_256: mrrs_dist = 11'd64 - {5'b0, cur_addr[5:0]};
            rd_pkg::mrrs_512: mrrs_dist = 11'd128 - {4'b0, cur_addr[6:0]};
            default:          mrrs_dist = 11'd32 - {6'b0, cur_addr[4:0]};
        endcase
        page_dist = 11'd1024 - {1'b0, cur_addr[9:0]};
        // smallest of the three limits
        step = cur_len;
        if (mrrs_dist < step) begin
            step = mrrs_dist;
        end
        if (page_dist < step) begin
            step = page_dist;
        end
    end

    assign req_ready = (state == st_idle) && cfg.dma_en;
    assign hdr_valid = (state == st_busy);
    assign hdr.addr  = cur_addr;
    // a full 1024 dword step wraps to 0 as the encoding expects
    assign hdr.len   = step[9:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (req_xfer) begin
                        state <= st_busy;
                    end
                end
                default: begin
                    if (hdr_xfer && (step == cur_len)) begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // remaining part of the request
    always_ff @(posedge clk) begin
        if (req_xfer) begin
            cur_addr <= req.addr;
            cur_len  <= req.len;
        end else if (hdr_xfer) begin
            cur_addr <= cur_addr + {{(rd_pkg::addr_w-11){1'b0}}, step};
            cur_len  <= cur_len - step;
        end
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the read path testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module rd_tb -f files.f -o rd_tb_sim
./obj_dir/rd_tb_sim | tee sim.log

if grep -qF "*** PASSED ***" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== verification/rd_tb.sv ====
`timescale 1ns/10ps

module rd_tb;

    // dwords requested over all tests, 4 cycles each plus fixed waits
    localparam int total_dw     = 300 + 1 + 20 + 512 + 40;
    localparam int limit_cycles = total_dw * 4 + 400;

    logic              clk;
    logic              rst;
    logic              req_valid;
    logic              req_ready;
    rd_pkg::rd_req_t   req;
    logic              tlp_valid;
    logic              tlp_ready;
    rd_pkg::rd_tlp_t   tlp;
    logic              cpl_valid;
    rd_pkg::cpl_beat_t cpl;
    logic              rsp_valid;
    rd_pkg::rsp_beat_t rsp;
    rd_pkg::reg_op_e   reg_op;
    logic [7:0]        reg_wdata;
    logic [7:0]        reg_rdata;
    logic              pending;

    // link model and scoreboard
    rd_pkg::rd_tlp_t   exp_tlp[$];
    rd_pkg::rd_tlp_t   issued[$];
    int                issued_bufa[$];
    rd_pkg::rsp_beat_t exp_rsp[$];
    int                next_tag = 0;
    int                buf_next = 0;
    int                n_issued = 0;
    int                mrrs_dw = 32;
    int                rcb_dw = 16;
    bit                cpl_hold = 1'b0;
    bit                cpl_busy = 1'b0;
    logic [31:0]       seed = 32'hd997;
    string             cur_test = "reset";
    int                pass_cnt = 0;
    int                fail_cnt = 0;

    rd_tb_clk i_clk (.clk(clk), .rst(rst));

    rd_outbound_top i_dut (
        .clk(clk), .rst(rst), .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .tlp_valid(tlp_valid), .tlp_ready(tlp_ready), .tlp(tlp),
        .cpl_valid(cpl_valid), .cpl(cpl), .rsp_valid(rsp_valid), .rsp(rsp),
        .reg_op(reg_op), .reg_wdata(reg_wdata), .reg_rdata(reg_rdata), .pending(pending)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic int len_dwords(input logic [9:0] len);
        return (len == 10'd0) ? 1024 : int'(len);
    endfunction

    task automatic check_tlp(input rd_pkg::rd_tlp_t exp, input rd_pkg::rd_tlp_t act);
        if (act !== exp) begin
            $display("error %s tlp expected %h actual %h", cur_test, exp, act);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_rsp(input rd_pkg::rsp_beat_t exp, input rd_pkg::rsp_beat_t act);
        if (act !== exp) begin
            $display("error %s rsp expected %h actual %h", cur_test, exp, act);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic check_bit(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("error %s %s expected %h actual %h", cur_test, what, exp, act);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    task automatic report_test(input int errs_before);
        $display("test %s finished with %0d errors", cur_test, fail_cnt - errs_before);
    endtask

    // expected headers by the split rule, tags round robin
    task automatic expect_headers(input int addr, input int len);
        rd_pkg::rd_tlp_t t;
        int              step;
        while (len > 0) begin
            step = len;
            if (mrrs_dw - addr % mrrs_dw < step) begin
                step = mrrs_dw - addr % mrrs_dw;
            end
            if (1024 - addr % 1024 < step) begin
                step = 1024 - addr % 1024;
            end
            t.addr     = rd_pkg::addr_w'(addr);
            t.len      = 10'(step);
            t.tag      = rd_pkg::tag_w'(next_tag);
            t.be_first = 4'hf;
            t.be_last  = (step == 1) ? 4'h0 : 4'hf;
            exp_tlp.push_back(t);
            next_tag = (next_tag + 1) % (1 << rd_pkg::tag_w);
            addr += step;
            len -= step;
        end
    endtask

    task automatic send_request(input int addr, input int len);
        logic taken;
        expect_headers(addr, len);
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= {rd_pkg::addr_w'(addr), 11'(len)};
        taken = 1'b0;
        // ready is looked at mid cycle, the transfer happens on the next edge
        while (!taken) begin
            @(negedge clk);
            taken = req_ready;
            @(posedge clk);
        end
        req_valid <= 1'b0;
    endtask

    task automatic write_ctrl(input logic [7:0] v);
        @(posedge clk);
        reg_op    <= rd_pkg::op_wr_ctrl;
        reg_wdata <= v;
        @(posedge clk);
        reg_op <= rd_pkg::op_nop;
        rcb_dw  = v[1] ? 32 : 16;
        mrrs_dw = 32 << v[3:2];
    endtask

    task automatic read_status(output logic [7:0] v);
        @(posedge clk);
        reg_op <= rd_pkg::op_rd_status;
        @(posedge clk);
        reg_op <= rd_pkg::op_nop;
        @(negedge clk);
        v = reg_rdata;
    endtask

    task automatic wait_idle();
        @(negedge clk);
        while (exp_tlp.size() != 0 || issued.size() != 0 || cpl_busy || exp_rsp.size() != 0) begin
            @(negedge clk);
        end
    endtask

    // completions of one header, split at rcb boundaries
    task automatic return_completions(input rd_pkg::rd_tlp_t t, input int bufa);
        int                n;
        int                a;
        logic              eop;
        logic              last;
        rd_pkg::rsp_beat_t r;
        n = len_dwords(t.len);
        a = int'(t.addr);
        @(posedge clk);
        for (int i = 0; i < n; i++) begin
            seed = lcg_next(seed);
            last = (i == n - 1);
            eop  = last || ((a + i + 1) % rcb_dw == 0);
            cpl_valid <= 1'b1;
            cpl       <= {t.tag, seed, eop};
            r = {t.tag, rd_pkg::bufa_w'((bufa + i) % 512), seed, last};
            exp_rsp.push_back(r);
            @(posedge clk);
        end
        cpl_valid <= 1'b0;
    endtask

    initial begin
        cpl_valid <= 1'b0;
        cpl       <= '0;
        forever begin
            @(negedge clk);
            if (!cpl_hold && issued.size() > 0) begin
                cpl_busy = 1'b1;
                return_completions(issued.pop_front(), issued_bufa.pop_front());
                cpl_busy = 1'b0;
            end
        end
    end

    // header and response monitor
    always @(posedge clk) begin
        if (!rst && tlp_valid && tlp_ready) begin
            if (exp_tlp.size() == 0) begin
                $display("test %s got a header that no request asked for: %h", cur_test, tlp);
                fail_cnt++;
            end else begin
                check_tlp(exp_tlp.pop_front(), tlp);
            end
            issued.push_back(tlp);
            issued_bufa.push_back(buf_next);
            buf_next = (buf_next + len_dwords(tlp.len)) % 512;
            n_issued++;
        end
        if (!rst && rsp_valid) begin
            if (exp_rsp.size() == 0) begin
                $display("test %s got a response beat with no completion behind it", cur_test);
                fail_cnt++;
            end else begin
                check_rsp(exp_rsp.pop_front(), rsp);
            end
        end
    end

    task automatic test_enable_gating();
        int         errs;
        int         accepted;
        logic [7:0] st;
        errs = fail_cnt;
        cur_test = "enable_gating";
        accepted = 0;
        @(posedge clk);
        req_valid <= 1'b1;
        req       <= {rd_pkg::addr_w'(32'h100), 11'd4};
        // long enough to cover tag table init
        repeat (40) begin
            @(negedge clk);
            if (req_ready) begin
                accepted++;
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;
        if (accepted != 0 || n_issued != 0) begin
            $display("test %s: request taken while bus mastering was off", cur_test);
            fail_cnt++;
        end
        write_ctrl(8'h0b);
        read_status(st);
        check_bit("status", 8'h0b, st);
        write_ctrl(8'h01);
        read_status(st);
        check_bit("status", 8'h01, st);
        report_test(errs);
    endtask

    task automatic test_splitting();
        int errs;
        errs = fail_cnt;
        cur_test = "splitting";
        // 8 dwords below a 4 KB boundary
        send_request(5 * 1024 - 8, 300);
        wait_idle();
        report_test(errs);
    endtask

    task automatic test_responses();
        int errs;
        errs = fail_cnt;
        cur_test = "responses";
        send_request(32'h2100, 1);
        send_request(32'h2007, 20);
        wait_idle();
        check_bit("pending", 8'h00, {7'b0, pending});
        report_test(errs);
    endtask

    task automatic test_credit_stall();
        int errs;
        int quiet;
        int last_cnt;
        int a;
        int n;
        int sum_h;
        int sum_d;
        int sum_b;
        errs = fail_cnt;
        cur_test = "credit_stall";
        cpl_hold = 1'b1;
        send_request(32'h4000, 512);
        quiet = 0;
        last_cnt = n_issued;
        // stalled once nothing issues for a while
        while (quiet < 20) begin
            @(negedge clk);
            quiet = (n_issued != last_cnt) ? 0 : quiet + 1;
            last_cnt = n_issued;
        end
        sum_h = 0;
        sum_d = 0;
        sum_b = 0;
        foreach (issued[i]) begin
            a = int'(issued[i].addr);
            n = len_dwords(issued[i].len);
            sum_h += (a % rcb_dw + n + rcb_dw - 1) / rcb_dw;
            sum_d += (a % 4 + n + 3) / 4;
            sum_b += n;
        end
        if (sum_h > rd_pkg::cplh_credits || sum_d > rd_pkg::cpld_credits || sum_b > 512) begin
            $display("test %s: outstanding headers use %0d/%0d/%0d credits, over the limit",
                     cur_test, sum_h, sum_d, sum_b);
            fail_cnt++;
        end
        if (issued.size() == 0 || exp_tlp.size() == 0) begin
            $display("test %s: issuing did not stop at the credit limit", cur_test);
            fail_cnt++;
        end
        check_bit("pending", 8'h01, {7'b0, pending});
        cpl_hold = 1'b0;
        wait_idle();
        report_test(errs);
    endtask

    task automatic test_backpressure();
        int              errs;
        rd_pkg::rd_tlp_t held;
        errs = fail_cnt;
        cur_test = "backpressure";
        @(posedge clk);
        tlp_ready <= 1'b0;
        // two headers, the second waits behind the held one
        send_request(32'h6010, 40);
        @(negedge clk);
        while (!tlp_valid) begin
            @(negedge clk);
        end
        held = exp_tlp[0];
        check_bit("pending", 8'h01, {7'b0, pending});
        repeat (8) begin
            @(negedge clk);
            check_tlp(held, tlp);
            check_bit("tlp_valid", 8'h01, {7'b0, tlp_valid});
        end
        @(posedge clk);
        tlp_ready <= 1'b1;
        wait_idle();
        check_bit("pending", 8'h00, {7'b0, pending});
        report_test(errs);
    endtask

    initial begin
        req_valid <= 1'b0;
        req       <= '0;
        tlp_ready <= 1'b1;
        reg_op    <= rd_pkg::op_nop;
        reg_wdata <= 8'h00;
        @(negedge rst);
        test_enable_gating();
        test_splitting();
        test_responses();
        test_credit_stall();
        test_backpressure();
        $display("checks passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        repeat (limit_cycles) @(posedge clk);
        $display("watchdog expired after %0d cycles in test %s", limit_cycles, cur_test);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== verification/rd_tb_clk.sv ====
`timescale 1ns/10ps

module rd_tb_clk (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held over the first 8 rising edges
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule
